//--- design/sa_ctrl_pkg.sv
package sa_ctrl_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    localparam int OPCODE_BITS      = 4;
    localparam int OFFMEM_ADDR_BITS = 32;
    // Opcode on top, then write address, then read address
    localparam int INST_BITS        = OPCODE_BITS + 2 * OFFMEM_ADDR_BITS;
    localparam int DATA_BITS        = 128;
    localparam int UB_ADDR_BITS     = 8;
    localparam int ACC_ADDR_BITS    = 6;

    //////////////////////////////
    // Types
    //////////////////////////////

    typedef logic [INST_BITS-1:0]        inst_t;
    typedef logic [OFFMEM_ADDR_BITS-1:0] offmem_addr_t;
    typedef logic [UB_ADDR_BITS-1:0]     ub_addr_t;
    typedef logic [ACC_ADDR_BITS-1:0]    acc_addr_t;
    typedef logic [DATA_BITS-1:0]        data_t;

    // Codes 2, 4, 6 and 11 to 15 are left free and run as no-ops
    typedef enum logic [OPCODE_BITS-1:0] {
        OP_IDLE            = 4'h0,
        OP_DATA_FIFO       = 4'h1,
        OP_AXI_TO_UB       = 4'h3,
        OP_UB_TO_DATA_FIFO = 4'h5,
        OP_MAT_MUL         = 4'h7,
        OP_MAT_MUL_ACC     = 4'h8,
        OP_ACC_TO_UB       = 4'h9,
        OP_UB_TO_AXI       = 4'ha
    } opcode_e;

    // Mode of the off-chip memory master
    typedef enum logic [1:0] {
        AXI_IDLE  = 2'd0,
        AXI_LOAD  = 2'd1,
        AXI_WRITE = 2'd2
    } axi_mode_e;

    typedef enum logic [1:0] {
        STEP_0,
        STEP_1,
        STEP_2
    } step_e;

endpackage

//--- design/cu_ctrl_if.sv
`timescale 1ns/1ps

interface cu_ctrl_if;

    // Current instruction and its progress
    sa_ctrl_pkg::opcode_e      opcode;
    sa_ctrl_pkg::offmem_addr_t addra;
    sa_ctrl_pkg::offmem_addr_t addrb;
    sa_ctrl_pkg::step_e        step;
    bit                        done;

    modport seq (
        output opcode,
        output addra,
        output addrb,
        output step,
        output done
    );

    modport dec (
        input opcode,
        input addra,
        input addrb,
        input step,
        input done
    );

endinterface

//--- design/inst_sequencer.sv
`timescale 1ns/1ps

module inst_sequencer (
    input  logic                clk,
    input  logic                reset_n,
    input  sa_ctrl_pkg::inst_t  instruction,
    input  logic                txn_done,
    cu_ctrl_if.seq              ctrl
);

    sa_ctrl_pkg::opcode_e      inst_opcode;
    sa_ctrl_pkg::offmem_addr_t inst_addra;
    sa_ctrl_pkg::offmem_addr_t inst_addrb;

    sa_ctrl_pkg::opcode_e      opcode_q;
    sa_ctrl_pkg::step_e        step_q;
    sa_ctrl_pkg::step_e        step_next;
    sa_ctrl_pkg::offmem_addr_t addra_q;
    sa_ctrl_pkg::offmem_addr_t addrb_q;
    logic                      done;

    //////////////////////////////
    // Instruction fields
    //////////////////////////////

    // Undefined codes pass through the cast unchanged
    assign inst_opcode = sa_ctrl_pkg::opcode_e'(
        instruction[sa_ctrl_pkg::INST_BITS-1 -: sa_ctrl_pkg::OPCODE_BITS]);
    assign inst_addra = instruction[sa_ctrl_pkg::INST_BITS-sa_ctrl_pkg::OPCODE_BITS-1
                                    -: sa_ctrl_pkg::OFFMEM_ADDR_BITS];
    assign inst_addrb = instruction[sa_ctrl_pkg::OFFMEM_ADDR_BITS-1:0];

    //////////////////////////////
    // Completion
    //////////////////////////////

    always_comb begin
        case (opcode_q)
            sa_ctrl_pkg::OP_MAT_MUL,
            sa_ctrl_pkg::OP_MAT_MUL_ACC,
            sa_ctrl_pkg::OP_ACC_TO_UB: begin
                done = (step_q == sa_ctrl_pkg::STEP_1);
            end
            // Waiting steps finish on the master's done strobe
            sa_ctrl_pkg::OP_AXI_TO_UB: begin
                done = (step_q == sa_ctrl_pkg::STEP_1) && txn_done;
            end
            sa_ctrl_pkg::OP_UB_TO_AXI: begin
                done = (step_q == sa_ctrl_pkg::STEP_2) && txn_done;
            end
            default: begin
                done = (step_q == sa_ctrl_pkg::STEP_0);
            end
        endcase
    end

    //////////////////////////////
    // Step advance
    //////////////////////////////

    always_comb begin
        step_next = step_q;
        case (opcode_q)
            sa_ctrl_pkg::OP_MAT_MUL,
            sa_ctrl_pkg::OP_MAT_MUL_ACC,
            sa_ctrl_pkg::OP_ACC_TO_UB,
            sa_ctrl_pkg::OP_AXI_TO_UB: begin
                if (step_q == sa_ctrl_pkg::STEP_0) begin
                    step_next = sa_ctrl_pkg::STEP_1;
                end
            end
            sa_ctrl_pkg::OP_UB_TO_AXI: begin
                if (step_q == sa_ctrl_pkg::STEP_0) begin
                    step_next = sa_ctrl_pkg::STEP_1;
                end else if (step_q == sa_ctrl_pkg::STEP_1) begin
                    step_next = sa_ctrl_pkg::STEP_2;
                end
            end
            default: begin
                step_next = step_q;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            opcode_q <= sa_ctrl_pkg::OP_IDLE;
            step_q   <= sa_ctrl_pkg::STEP_0;
            addra_q  <= '0;
            addrb_q  <= '0;
        end else if (done) begin
            // Take the next instruction
            opcode_q <= inst_opcode;
            step_q   <= sa_ctrl_pkg::STEP_0;
            addra_q  <= inst_addra;
            addrb_q  <= inst_addrb;
        end else begin
            step_q   <= step_next;
        end
    end

    assign ctrl.opcode = opcode_q;
    assign ctrl.step   = step_q;
    assign ctrl.addra  = addra_q;
    assign ctrl.addrb  = addrb_q;
    assign ctrl.done   = done;

endmodule

//--- design/strobe_decoder.sv
`timescale 1ns/1ps

module strobe_decoder (
    cu_ctrl_if.dec                    ctrl,
    input  sa_ctrl_pkg::data_t        din,
    input  sa_ctrl_pkg::data_t        rin,
    input  sa_ctrl_pkg::data_t        uin,
    output sa_ctrl_pkg::axi_mode_e    axi_sm_mode,
    output logic                      init_txn_pulse,
    output logic                      read_ub,
    output logic                      write_ub,
    output logic                      read_acc,
    output logic                      write_acc,
    output logic                      data_fifo_en,
    output logic                      mm_en,
    output logic                      acc_en,
    output logic                      idle,
    output sa_ctrl_pkg::ub_addr_t     ub_addra,
    output sa_ctrl_pkg::ub_addr_t     ub_addrb,
    output sa_ctrl_pkg::acc_addr_t    acc_addra,
    output sa_ctrl_pkg::acc_addr_t    acc_addrb,
    output sa_ctrl_pkg::offmem_addr_t offmem_addra,
    output sa_ctrl_pkg::offmem_addr_t offmem_addrb,
    output sa_ctrl_pkg::data_t        dout
);

    sa_ctrl_pkg::ub_addr_t  ub_wr_addr;
    sa_ctrl_pkg::ub_addr_t  ub_rd_addr;
    sa_ctrl_pkg::acc_addr_t acc_wr_addr;
    sa_ctrl_pkg::acc_addr_t acc_rd_addr;

    // On-chip buffers see only the low address bits
    assign ub_wr_addr  = ctrl.addra[sa_ctrl_pkg::UB_ADDR_BITS-1:0];
    assign ub_rd_addr  = ctrl.addrb[sa_ctrl_pkg::UB_ADDR_BITS-1:0];
    assign acc_wr_addr = ctrl.addra[sa_ctrl_pkg::ACC_ADDR_BITS-1:0];
    assign acc_rd_addr = ctrl.addrb[sa_ctrl_pkg::ACC_ADDR_BITS-1:0];

    assign idle = (ctrl.opcode == sa_ctrl_pkg::OP_IDLE);

    //////////////////////////////
    // Output table
    //////////////////////////////

    always_comb begin
        axi_sm_mode    = sa_ctrl_pkg::AXI_IDLE;
        init_txn_pulse = 1'b0;
        read_ub        = 1'b0;
        write_ub       = 1'b0;
        read_acc       = 1'b0;
        write_acc      = 1'b0;
        data_fifo_en   = 1'b0;
        mm_en          = 1'b0;
        acc_en         = 1'b0;
        ub_addra       = '0;
        ub_addrb       = '0;
        acc_addra      = '0;
        acc_addrb      = '0;
        offmem_addra   = '0;
        offmem_addrb   = '0;
        dout           = '0;

        case (ctrl.opcode)
            sa_ctrl_pkg::OP_DATA_FIFO: begin
                data_fifo_en = 1'b1;
            end

            sa_ctrl_pkg::OP_UB_TO_DATA_FIFO: begin
                read_ub      = 1'b1;
                data_fifo_en = 1'b1;
                ub_addrb     = ub_rd_addr;
            end

            sa_ctrl_pkg::OP_MAT_MUL,
            sa_ctrl_pkg::OP_MAT_MUL_ACC: begin
                // Accumulate mode keeps acc_en over both steps
                acc_en = (ctrl.opcode == sa_ctrl_pkg::OP_MAT_MUL_ACC);
                if (ctrl.step == sa_ctrl_pkg::STEP_0) begin
                    read_ub  = 1'b1;
                    ub_addrb = ub_rd_addr;
                end else begin
                    write_acc    = 1'b1;
                    data_fifo_en = 1'b1;
                    mm_en        = 1'b1;
                    acc_addra    = acc_wr_addr;
                end
            end

            sa_ctrl_pkg::OP_ACC_TO_UB: begin
                if (ctrl.step == sa_ctrl_pkg::STEP_0) begin
                    read_acc  = 1'b1;
                    acc_addrb = acc_rd_addr;
                end else begin
                    write_ub = 1'b1;
                    ub_addra = ub_wr_addr;
                    dout     = rin;
                end
            end

            sa_ctrl_pkg::OP_AXI_TO_UB: begin
                if (ctrl.step == sa_ctrl_pkg::STEP_0) begin
                    axi_sm_mode    = sa_ctrl_pkg::AXI_LOAD;
                    init_txn_pulse = 1'b1;
                    offmem_addrb   = ctrl.addrb;
                end else if (!ctrl.done) begin
                    // Hold the load request until the data comes back
                    axi_sm_mode  = sa_ctrl_pkg::AXI_LOAD;
                    offmem_addrb = ctrl.addrb;
                end else begin
                    write_ub = 1'b1;
                    ub_addra = ub_wr_addr;
                    dout     = din;
                end
            end

            sa_ctrl_pkg::OP_UB_TO_AXI: begin
                if (ctrl.step == sa_ctrl_pkg::STEP_0) begin
                    read_ub  = 1'b1;
                    ub_addrb = ub_rd_addr;
                end else begin
                    axi_sm_mode    = sa_ctrl_pkg::AXI_WRITE;
                    init_txn_pulse = (ctrl.step == sa_ctrl_pkg::STEP_1);
                    offmem_addra   = ctrl.addra;
                    dout           = uin;
                end
            end

            default: begin
                // Idle and free codes leave every strobe low
                axi_sm_mode = sa_ctrl_pkg::AXI_IDLE;
            end
        endcase
    end

endmodule

//--- design/sa_ctrl_top.sv
`timescale 1ns/1ps

module sa_ctrl_top (
    input  logic                      clk,
    input  logic                      reset_n,
    input  sa_ctrl_pkg::inst_t        instruction,
    input  logic                      txn_done,
    input  sa_ctrl_pkg::data_t        din,
    input  sa_ctrl_pkg::data_t        rin,
    input  sa_ctrl_pkg::data_t        uin,
    output logic                      inst_req,
    output sa_ctrl_pkg::axi_mode_e    axi_sm_mode,
    output logic                      init_txn_pulse,
    output logic                      read_ub,
    output logic                      write_ub,
    output logic                      read_acc,
    output logic                      write_acc,
    output logic                      data_fifo_en,
    output logic                      mm_en,
    output logic                      acc_en,
    output logic                      idle,
    output sa_ctrl_pkg::ub_addr_t     ub_addra,
    output sa_ctrl_pkg::ub_addr_t     ub_addrb,
    output sa_ctrl_pkg::acc_addr_t    acc_addra,
    output sa_ctrl_pkg::acc_addr_t    acc_addrb,
    output sa_ctrl_pkg::offmem_addr_t offmem_addra,
    output sa_ctrl_pkg::offmem_addr_t offmem_addrb,
    output sa_ctrl_pkg::data_t        dout
);

    cu_ctrl_if ctrl_if ();

    //////////////////////////////
    // Sequencer and decoder
    //////////////////////////////

    inst_sequencer u_inst_sequencer (
        .clk         (clk),
        .reset_n     (reset_n),
        .instruction (instruction),
        .txn_done    (txn_done),
        .ctrl        (ctrl_if.seq)
    );

    strobe_decoder u_strobe_decoder (
        .ctrl           (ctrl_if.dec),
        .din            (din),
        .rin            (rin),
        .uin            (uin),
        .axi_sm_mode    (axi_sm_mode),
        .init_txn_pulse (init_txn_pulse),
        .read_ub        (read_ub),
        .write_ub       (write_ub),
        .read_acc       (read_acc),
        .write_acc      (write_acc),
        .data_fifo_en   (data_fifo_en),
        .mm_en          (mm_en),
        .acc_en         (acc_en),
        .idle           (idle),
        .ub_addra       (ub_addra),
        .ub_addrb       (ub_addrb),
        .acc_addra      (acc_addra),
        .acc_addrb      (acc_addrb),
        .offmem_addra   (offmem_addra),
        .offmem_addrb   (offmem_addrb),
        .dout           (dout)
    );

    // Next instruction is requested in the completing cycle
    assign inst_req = ctrl_if.done;

endmodule

//--- verification/tb_sa_ctrl_tasks.svh
//////////////////////////////
// Compare tasks
//////////////////////////////

task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1);
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
        fail_now($sformatf("Mismatch at %0d ns: %s is %b, expected %b", $time, what, got, exp));
endtask

task automatic check_strobes(input string what, input logic [8:0] got, input logic [8:0] exp);
    if (got !== exp)
        fail_now($sformatf("Mismatch at %0d ns: %s are %b, expected %b", $time, what, got, exp));
endtask

task automatic check_mode(input string what, input sa_ctrl_pkg::axi_mode_e got,
                          input sa_ctrl_pkg::axi_mode_e exp);
    if (got !== exp)
        fail_now($sformatf("Mismatch at %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
endtask

task automatic check_ub_addr(input string what, input sa_ctrl_pkg::ub_addr_t got,
                             input sa_ctrl_pkg::ub_addr_t exp);
    if (got !== exp)
        fail_now($sformatf("Mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic check_acc_addr(input string what, input sa_ctrl_pkg::acc_addr_t got,
                              input sa_ctrl_pkg::acc_addr_t exp);
    if (got !== exp)
        fail_now($sformatf("Mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic check_offmem_addr(input string what, input sa_ctrl_pkg::offmem_addr_t got,
                                 input sa_ctrl_pkg::offmem_addr_t exp);
    if (got !== exp)
        fail_now($sformatf("Mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic check_data(input string what, input sa_ctrl_pkg::data_t got,
                          input sa_ctrl_pkg::data_t exp);
    if (got !== exp)
        fail_now($sformatf("Mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic check_count(input string what, input int got, input int exp);
    if (got != exp)
        fail_now($sformatf("Mismatch at %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
endtask

//////////////////////////////
// Stimulus helpers
//////////////////////////////

function automatic sa_ctrl_pkg::inst_t make_inst(input logic [3:0] op,
                                                 input sa_ctrl_pkg::offmem_addr_t a,
                                                 input sa_ctrl_pkg::offmem_addr_t b);
    return {op, a, b};
endfunction

function automatic sa_ctrl_pkg::offmem_addr_t rand_addr();
    return $random(seed);
endfunction

// Sample point sits 10 ns after the falling edge
task automatic advance();
    @(negedge clk);
    #10;
endtask

task automatic present(input sa_ctrl_pkg::inst_t inst);
    @(negedge clk);
    instruction = inst;
    din = {$random(seed), $random(seed), $random(seed), $random(seed)};
    rin = {$random(seed), $random(seed), $random(seed), $random(seed)};
    uin = {$random(seed), $random(seed), $random(seed), $random(seed)};
    #10;
endtask

// Wait for the current instruction to be taken, then queue the next one
task automatic enter(input sa_ctrl_pkg::inst_t follow);
    int waited;
    waited = 0;
    while (!inst_req) begin
        advance();
        waited++;
        if (waited > 20)
            fail_now("Timed out waiting for inst_req");
    end
    @(negedge clk);
    instruction = follow;
    #10;
endtask

function automatic logic [8:0] step0_strobes(input sa_ctrl_pkg::opcode_e op);
    case (op)
        sa_ctrl_pkg::OP_DATA_FIFO:       return 9'b0_0000_1000;
        sa_ctrl_pkg::OP_UB_TO_DATA_FIFO: return 9'b0_1000_1000;
        sa_ctrl_pkg::OP_MAT_MUL:         return 9'b0_1000_0000;
        sa_ctrl_pkg::OP_MAT_MUL_ACC:     return 9'b0_1000_0010;
        sa_ctrl_pkg::OP_ACC_TO_UB:       return 9'b0_0010_0000;
        sa_ctrl_pkg::OP_AXI_TO_UB:       return 9'b1_0000_0000;
        sa_ctrl_pkg::OP_UB_TO_AXI:       return 9'b0_1000_0000;
        default:                         return 9'b0_0000_0001;
    endcase
endfunction

function automatic int latency(input sa_ctrl_pkg::opcode_e op, input int delay);
    case (op)
        sa_ctrl_pkg::OP_MAT_MUL,
        sa_ctrl_pkg::OP_MAT_MUL_ACC,
        sa_ctrl_pkg::OP_ACC_TO_UB: return 2;
        sa_ctrl_pkg::OP_AXI_TO_UB: return 1 + delay;
        sa_ctrl_pkg::OP_UB_TO_AXI: return 2 + delay;
        default:                   return 1;
    endcase
endfunction

//////////////////////////////
// Directed tests
//////////////////////////////

task automatic test_reset_state();
    check_strobes("reset strobes", strobes, 9'b0_0000_0001);
    check_mode("reset axi_sm_mode", axi_sm_mode, sa_ctrl_pkg::AXI_IDLE);
    check_ub_addr("reset ub_addra", ub_addra, '0);
    check_ub_addr("reset ub_addrb", ub_addrb, '0);
    check_acc_addr("reset acc_addra", acc_addra, '0);
    check_acc_addr("reset acc_addrb", acc_addrb, '0);
    check_offmem_addr("reset offmem_addra", offmem_addra, '0);
    check_offmem_addr("reset offmem_addrb", offmem_addrb, '0);
    check_data("reset dout", dout, '0);
    check_bit("reset inst_req", inst_req, 1'b1);
endtask

task automatic test_one_step();
    logic [3:0] codes [3];
    logic [8:0] exp_strobes [3];
    sa_ctrl_pkg::offmem_addr_t a;
    sa_ctrl_pkg::offmem_addr_t b;
    codes = '{sa_ctrl_pkg::OP_DATA_FIFO, sa_ctrl_pkg::OP_UB_TO_DATA_FIFO, 4'h2};
    exp_strobes = '{9'b0_0000_1000, 9'b0_1000_1000, 9'b0_0000_0000};
    for (int i = 0; i < 3; i++) begin
        a = rand_addr();
        b = rand_addr();
        present(make_inst(codes[i], a, b));
        enter(make_inst(sa_ctrl_pkg::OP_IDLE, '0, '0));
        check_strobes("one-step strobes", strobes, exp_strobes[i]);
        check_ub_addr("one-step ub_addrb", ub_addrb, (i == 1) ? b[7:0] : 8'h00);
        check_bit("one-step inst_req", inst_req, 1'b1);
    end
    advance();
    check_bit("idle after IDLE", idle, 1'b1);
endtask

task automatic test_two_step();
    logic [3:0] codes [3];
    logic [8:0] first [3];
    logic [8:0] second [3];
    sa_ctrl_pkg::offmem_addr_t a;
    sa_ctrl_pkg::offmem_addr_t b;
    codes = '{sa_ctrl_pkg::OP_MAT_MUL, sa_ctrl_pkg::OP_MAT_MUL_ACC, sa_ctrl_pkg::OP_ACC_TO_UB};
    first = '{9'b0_1000_0000, 9'b0_1000_0010, 9'b0_0010_0000};
    second = '{9'b0_0001_1100, 9'b0_0001_1110, 9'b0_0100_0000};
    for (int i = 0; i < 3; i++) begin
        a = rand_addr();
        b = rand_addr();
        present(make_inst(codes[i], a, b));
        enter(make_inst(sa_ctrl_pkg::OP_IDLE, '0, '0));
        check_strobes("step 0 strobes", strobes, first[i]);
        check_bit("step 0 inst_req", inst_req, 1'b0);
        if (i < 2)
            check_ub_addr("step 0 ub_addrb", ub_addrb, b[7:0]);
        else
            check_acc_addr("step 0 acc_addrb", acc_addrb, b[5:0]);
        advance();
        check_strobes("step 1 strobes", strobes, second[i]);
        check_bit("step 1 inst_req", inst_req, 1'b1);
        if (i < 2) begin
            check_acc_addr("step 1 acc_addra", acc_addra, a[5:0]);
        end else begin
            check_ub_addr("step 1 ub_addra", ub_addra, a[7:0]);
            check_data("step 1 dout", dout, rin);
        end
    end
endtask

task automatic test_axi_load();
    sa_ctrl_pkg::offmem_addr_t a;
    sa_ctrl_pkg::offmem_addr_t b;
    int waited;
    a = rand_addr();
    b = rand_addr();
    waited = 0;
    present(make_inst(sa_ctrl_pkg::OP_AXI_TO_UB, a, b));
    enter(make_inst(sa_ctrl_pkg::OP_IDLE, '0, '0));
    check_strobes("load start strobes", strobes, 9'b1_0000_0000);
    check_mode("load start mode", axi_sm_mode, sa_ctrl_pkg::AXI_LOAD);
    check_offmem_addr("load offmem_addrb", offmem_addrb, b);
    check_bit("load start inst_req", inst_req, 1'b0);
    advance();
    while (!inst_req) begin
        check_strobes("load wait strobes", strobes, 9'b0_0000_0000);
        check_mode("load wait mode", axi_sm_mode, sa_ctrl_pkg::AXI_LOAD);
        check_offmem_addr("load wait offmem_addrb", offmem_addrb, b);
        advance();
        waited++;
        if (waited > 10)
            fail_now("Timed out waiting for txn_done on the load");
    end
    check_bit("load txn_done", txn_done, 1'b1);
    check_strobes("load done strobes", strobes, 9'b0_0100_0000);
    check_ub_addr("load ub_addra", ub_addra, a[7:0]);
    check_data("load dout", dout, din);
    check_mode("load done mode", axi_sm_mode, sa_ctrl_pkg::AXI_IDLE);
endtask

task automatic test_axi_write();
    sa_ctrl_pkg::offmem_addr_t a;
    sa_ctrl_pkg::offmem_addr_t b;
    int waited;
    a = rand_addr();
    b = rand_addr();
    waited = 0;
    present(make_inst(sa_ctrl_pkg::OP_UB_TO_AXI, a, b));
    enter(make_inst(sa_ctrl_pkg::OP_IDLE, '0, '0));
    check_strobes("write read strobes", strobes, 9'b0_1000_0000);
    check_ub_addr("write ub_addrb", ub_addrb, b[7:0]);
    check_bit("write step 0 inst_req", inst_req, 1'b0);
    advance();
    check_strobes("write start strobes", strobes, 9'b1_0000_0000);
    check_mode("write start mode", axi_sm_mode, sa_ctrl_pkg::AXI_WRITE);
    check_offmem_addr("write offmem_addra", offmem_addra, a);
    check_data("write dout", dout, uin);
    check_bit("write start inst_req", inst_req, 1'b0);
    advance();
    while (!inst_req) begin
        check_strobes("write wait strobes", strobes, 9'b0_0000_0000);
        check_mode("write wait mode", axi_sm_mode, sa_ctrl_pkg::AXI_WRITE);
        advance();
        waited++;
        if (waited > 10)
            fail_now("Timed out waiting for txn_done on the write");
    end
    check_bit("write txn_done", txn_done, 1'b1);
    check_strobes("write done strobes", strobes, 9'b0_0000_0000);
    check_mode("write done mode", axi_sm_mode, sa_ctrl_pkg::AXI_WRITE);
    check_offmem_addr("write done offmem_addra", offmem_addra, a);
    check_data("write done dout", dout, uin);
endtask

task automatic test_back_to_back();
    sa_ctrl_pkg::opcode_e kept [8];
    sa_ctrl_pkg::opcode_e ops [16];
    sa_ctrl_pkg::inst_t   insts [16];
    int                   cycles;
    kept = '{sa_ctrl_pkg::OP_IDLE, sa_ctrl_pkg::OP_DATA_FIFO, sa_ctrl_pkg::OP_AXI_TO_UB,
             sa_ctrl_pkg::OP_UB_TO_DATA_FIFO, sa_ctrl_pkg::OP_MAT_MUL,
             sa_ctrl_pkg::OP_MAT_MUL_ACC, sa_ctrl_pkg::OP_ACC_TO_UB,
             sa_ctrl_pkg::OP_UB_TO_AXI};
    for (int i = 0; i < 16; i++) begin
        ops[i] = kept[$unsigned($random(seed)) % 32'd8];
        insts[i] = make_inst(ops[i], rand_addr(), rand_addr());
    end
    present(insts[0]);
    enter(insts[1]);
    for (int i = 0; i < 16; i++) begin
        check_strobes("sequence step 0 strobes", strobes, step0_strobes(ops[i]));
        cycles = 1;
        while (!inst_req) begin
            advance();
            cycles++;
            if (cycles > 20)
                fail_now("Timed out waiting for inst_req in the sequence");
        end
        check_count("sequence latency", cycles, latency(ops[i], txn_delay));
        if (i < 15)
            enter((i < 14) ? insts[i + 2] : make_inst(sa_ctrl_pkg::OP_IDLE, '0, '0));
    end
endtask

//--- verification/tb_sa_ctrl.sv
`timescale 1ns/1ps

module tb_sa_ctrl;

    logic                      clk;
    logic                      reset_n;
    sa_ctrl_pkg::inst_t        instruction;
    logic                      txn_done;
    sa_ctrl_pkg::data_t        din;
    sa_ctrl_pkg::data_t        rin;
    sa_ctrl_pkg::data_t        uin;
    logic                      inst_req;
    sa_ctrl_pkg::axi_mode_e    axi_sm_mode;
    logic                      init_txn_pulse;
    logic                      read_ub;
    logic                      write_ub;
    logic                      read_acc;
    logic                      write_acc;
    logic                      data_fifo_en;
    logic                      mm_en;
    logic                      acc_en;
    logic                      idle;
    sa_ctrl_pkg::ub_addr_t     ub_addra;
    sa_ctrl_pkg::ub_addr_t     ub_addrb;
    sa_ctrl_pkg::acc_addr_t    acc_addra;
    sa_ctrl_pkg::acc_addr_t    acc_addrb;
    sa_ctrl_pkg::offmem_addr_t offmem_addra;
    sa_ctrl_pkg::offmem_addr_t offmem_addrb;
    sa_ctrl_pkg::data_t        dout;

    // Strobes from init_txn_pulse down to idle
    logic [8:0]                strobes;

    int                        seed;
    int                        txn_count;
    int                        txn_delay;

    assign strobes = {init_txn_pulse, read_ub, write_ub, read_acc, write_acc,
                      data_fifo_en, mm_en, acc_en, idle};

    sa_ctrl_top DUT (
        .clk            (clk),
        .reset_n        (reset_n),
        .instruction    (instruction),
        .txn_done       (txn_done),
        .din            (din),
        .rin            (rin),
        .uin            (uin),
        .inst_req       (inst_req),
        .axi_sm_mode    (axi_sm_mode),
        .init_txn_pulse (init_txn_pulse),
        .read_ub        (read_ub),
        .write_ub       (write_ub),
        .read_acc       (read_acc),
        .write_acc      (write_acc),
        .data_fifo_en   (data_fifo_en),
        .mm_en          (mm_en),
        .acc_en         (acc_en),
        .idle           (idle),
        .ub_addra       (ub_addra),
        .ub_addrb       (ub_addrb),
        .acc_addra      (acc_addra),
        .acc_addrb      (acc_addrb),
        .offmem_addra   (offmem_addra),
        .offmem_addrb   (offmem_addrb),
        .dout           (dout)
    );

    always #50 clk = ~clk;

    //////////////////////////////
    // Off-chip master model
    //////////////////////////////

    // One-cycle txn_done 1 to 6 cycles after the start pulse
    always @(negedge clk) begin
        txn_done = 1'b0;
        if (!reset_n) begin
            txn_count = 0;
        end else if (txn_count > 0) begin
            txn_count = txn_count - 1;
            if (txn_count == 0) begin
                txn_done = 1'b1;
            end
        end else if (init_txn_pulse) begin
            txn_delay = 1 + int'($unsigned($random(seed)) % 32'd6);
            txn_count = txn_delay;
        end
    end

    `include "tb_sa_ctrl_tasks.svh"

    initial begin
        clk         = 1'b0;
        reset_n     = 1'b0;
        instruction = '0;
        txn_done    = 1'b0;
        din         = '0;
        rin         = '0;
        uin         = '0;
        seed        = 32'h1f27_0f8e;
        txn_count   = 0;
        txn_delay   = 0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        #10;

        test_reset_state();
        test_one_step();
        test_two_step();
        test_axi_load();
        test_axi_write();
        test_back_to_back();

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- files.f
+incdir+verification
design/sa_ctrl_pkg.sv
design/cu_ctrl_if.sv
design/inst_sequencer.sv
design/strobe_decoder.sv
design/sa_ctrl_top.sv
verification/tb_sa_ctrl.sv

//--- Makefile
TOP = tb_sa_ctrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f files.f --top-module $(TOP) -o V$(TOP)

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir
